// ==== filelist.f ====
+incdir+tb
source/mul_pkg.sv
source/partial_product_gen.sv
source/dadda_tree.sv
source/operand_stage.sv
source/reduce_stage.sv
source/resolve_stage.sv
source/mul32_dadda.sv
tb/tb_mul32.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_mul32 \
    -o sim_mul32
if [ $? -ne 0 ]
then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_mul32)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]
then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Done: no errors"
then
    exit 0
fi
exit 1

// ==== tb/mul_ref.svh ====
`ifndef MUL_REF_SVH
`define MUL_REF_SVH

// expected product, operands widened to 64 bits by the mode rule
function automatic mul_pkg::mul_rsp_t mul_ref(
    input mul_pkg::operand_t a,
    input mul_pkg::operand_t b,
    input logic              is_signed
);
    logic [2*mul_pkg::WIDTH-1:0] wide_a;
    logic [2*mul_pkg::WIDTH-1:0] wide_b;
    logic [2*mul_pkg::WIDTH-1:0] prod;
    mul_pkg::mul_rsp_t           rsp;
    if (is_signed)
    begin
        wide_a = {{mul_pkg::WIDTH{a[mul_pkg::WIDTH-1]}}, a};
        wide_b = {{mul_pkg::WIDTH{b[mul_pkg::WIDTH-1]}}, b};
    end
    else
    begin
        wide_a = {{mul_pkg::WIDTH{1'b0}}, a};
        wide_b = {{mul_pkg::WIDTH{1'b0}}, b};
    end
    // low 64 bits of the widened product are the two's-complement result
    prod = wide_a * wide_b;
    rsp.hi = prod[2*mul_pkg::WIDTH-1:mul_pkg::WIDTH];
    rsp.lo = prod[mul_pkg::WIDTH-1:0];
    return rsp;
endfunction

`endif

// ==== tb/tb_mul32.sv ====
module tb_mul32;

    localparam int TIMEOUT = 1000;
    localparam int N_RANDOM = 2000;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    mul_pkg::mul_req_t in_req;
    logic              out_ready;
    logic              in_ready;
    logic              out_valid;
    mul_pkg::mul_rsp_t out_rsp;

    mul_pkg::mul_rsp_t exp_q [$];
    int                stamp_q [$];
    mul_pkg::mul_rsp_t exp_rsp;
    mul_pkg::mul_rsp_t held_rsp;
    int                stamp;
    int                errors;
    int                out_count;
    int                cycle;
    int                last_out;
    logic              held;
    logic              timed_out;
    logic              bp_enable;
    logic              timing_check;
    logic              timing_first;
    string             test_name;

    `include "mul_ref.svh"

    mul32_dadda dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

    always #4 clk = ~clk;

    // random consumer stalls only while back-pressure is enabled
    always @(posedge clk)
    begin
        #1;
        out_ready = bp_enable ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    // a transfer seen at the falling edge completes at the next rising edge
    always @(negedge clk)
    begin
        cycle++;
        if (arst_n)
        begin
            if (in_valid && in_ready)
            begin
                exp_q.push_back(mul_ref(in_req.a, in_req.b, in_req.is_signed));
                stamp_q.push_back(cycle);
            end
            if (held)
            begin
                assert (out_valid && out_rsp == held_rsp)
                else
                begin
                    errors++;
                    $display("%s: output changed while stalled", test_name);
                end
            end
            held = out_valid && !out_ready;
            held_rsp = out_rsp;
            if (out_valid && out_ready)
            begin
                assert (exp_q.size() > 0)
                else
                begin
                    errors++;
                    $display("%s: output transfer with no request outstanding", test_name);
                end
                if (exp_q.size() > 0)
                begin
                    exp_rsp = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    out_count++;
                    assert (out_rsp == exp_rsp)
                    else
                    begin
                        errors++;
                        $display("[FAIL] %s: expected %h, actual %h", test_name, exp_rsp, out_rsp);
                    end
                    if (timing_check)
                    begin
                        // three edges from input transfer to output transfer
                        assert (cycle - stamp == 3)
                        else
                        begin
                            errors++;
                            $display("[FAIL] %s latency: expected %0d, actual %0d",
                                     test_name, 3, cycle - stamp);
                        end
                        if (!timing_first)
                        begin
                            assert (cycle - last_out == 1)
                            else
                            begin
                                errors++;
                                $display("[FAIL] %s spacing: expected %0d, actual %0d",
                                         test_name, 1, cycle - last_out);
                            end
                        end
                        timing_first = 1'b0;
                    end
                    last_out = cycle;
                end
            end
        end
    end

    task automatic flag_timeout(input string what);
        if (!timed_out)
        begin
            errors++;
            $display("%s: timed out waiting for %s", test_name, what);
        end
        timed_out = 1'b1;
    endtask

    // called a delay after a rising edge, returns the same way after the transfer
    task automatic send(input mul_pkg::operand_t a, input mul_pkg::operand_t b, input logic s);
        int waited;
        waited = 0;
        in_req.a = a;
        in_req.b = b;
        in_req.is_signed = s;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready && !timed_out && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (in_ready) else flag_timeout("in_ready");
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && !timed_out && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        assert (exp_q.size() == 0) else flag_timeout("pipeline drain");
        @(posedge clk);
        #1;
    endtask

    function automatic mul_pkg::operand_t pick_operand();
        case ($urandom_range(0, 7))
            0: return '0;
            1: return 32'h8000_0000;
            2: return 32'hffff_ffff;
            default: return $urandom;
        endcase
    endfunction

    task automatic check_reset();
        test_name = "reset";
        @(negedge clk);
        assert (!out_valid)
        else
        begin
            errors++;
            $display("[FAIL] %s out_valid: expected %b, actual %b", test_name, 1'b0, out_valid);
        end
        assert (in_ready)
        else
        begin
            errors++;
            $display("[FAIL] %s in_ready: expected %b, actual %b", test_name, 1'b1, in_ready);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_corners();
        // known products straight from the arithmetic
        test_name = "reference";
        assert (mul_ref(32'hffff_ffff, 32'hffff_ffff, 1'b0) == 64'hffff_fffe_0000_0001)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", test_name, 64'hffff_fffe_0000_0001,
                     mul_ref(32'hffff_ffff, 32'hffff_ffff, 1'b0));
        end
        assert (mul_ref(32'h8000_0000, 32'h8000_0000, 1'b1) == 64'h4000_0000_0000_0000)
        else
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", test_name, 64'h4000_0000_0000_0000,
                     mul_ref(32'h8000_0000, 32'h8000_0000, 1'b1));
        end
        test_name = "unsigned corners";
        send(32'h0, $urandom, 1'b0);
        send(32'hffff_ffff, 32'h0, 1'b0);
        send(32'h1, 32'hffff_ffff, 1'b0);
        send(32'hffff_ffff, 32'h1, 1'b0);
        send(32'hffff_ffff, 32'hffff_ffff, 1'b0);
        drain();
        test_name = "signed corners";
        send(32'hffff_ffff, 32'hffff_ffff, 1'b1);
        send(32'h8000_0000, 32'h8000_0000, 1'b1);
        send(32'h8000_0000, 32'h1, 1'b1);
        send(32'h1, 32'h8000_0000, 1'b1);
        send(32'h8000_0000, 32'hffff_ffff, 1'b1);
        send(32'h7fff_ffff, 32'h8000_0000, 1'b1);
        send(32'hffff_fff9, 32'h5, 1'b1);
        send(32'h7, 32'hffff_fffb, 1'b1);
        send(32'h0, 32'h8000_0000, 1'b1);
        drain();
    endtask

    task automatic run_random(input logic stall);
        test_name = stall ? "back-pressure stream" : "random stream";
        bp_enable = stall;
        for (int i = 0; i < N_RANDOM; i++)
        begin
            send(pick_operand(), pick_operand(), 1'($urandom_range(0, 1)));
            if ($urandom_range(0, 3) == 0)
            begin
                repeat ($urandom_range(1, 3)) @(posedge clk);
                #1;
            end
        end
        drain();
        bp_enable = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic run_timing();
        test_name = "latency and throughput";
        timing_first = 1'b1;
        timing_check = 1'b1;
        for (int i = 0; i < 16; i++)
            send($urandom, $urandom, 1'($urandom_range(0, 1)));
        drain();
        timing_check = 1'b0;
    endtask

    initial
    begin
        void'($urandom(32'hc8af99a4));
        clk = 1'b0;
        arst_n = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        out_ready = 1'b0;
        errors = 0;
        out_count = 0;
        cycle = 0;
        last_out = 0;
        held = 1'b0;
        held_rsp = '0;
        timed_out = 1'b0;
        bp_enable = 1'b0;
        timing_check = 1'b0;
        timing_first = 1'b1;
        test_name = "init";
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_reset();
        run_corners();
        run_random(1'b0);
        run_random(1'b1);
        run_timing();
        $display("results checked: %0d, errors: %0d", out_count, errors);
        if (errors == 0)
        begin
            $display("Done: no errors");
        end
        else
        begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== source/mul32_dadda.sv ====
module mul32_dadda (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  mul_pkg::mul_req_t in_req,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output mul_pkg::mul_rsp_t out_rsp
);

    // conditioned operands into the reduction stage
    logic           cond_valid;
    logic           cond_ready;
    mul_pkg::cond_t cond;

    // reduced rows into the final adder
    logic           rows_valid;
    logic           rows_ready;
    mul_pkg::rows_t rows;

    operand_stage operand_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .out_ready (cond_ready),
        .in_ready  (in_ready),
        .out_valid (cond_valid),
        .out_cond  (cond)
    );

    reduce_stage reduce_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (cond_valid),
        .in_cond   (cond),
        .out_ready (rows_ready),
        .in_ready  (cond_ready),
        .out_valid (rows_valid),
        .out_rows  (rows)
    );

    resolve_stage resolve_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (rows_valid),
        .in_rows   (rows),
        .out_ready (out_ready),
        .in_ready  (rows_ready),
        .out_valid (out_valid),
        .out_rsp   (out_rsp)
    );

endmodule

// ==== source/resolve_stage.sv ====
module resolve_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  mul_pkg::rows_t    in_rows,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output mul_pkg::mul_rsp_t out_rsp
);

    mul_pkg::product_t mag_prod;
    mul_pkg::product_t prod;
    mul_pkg::mul_rsp_t rsp_d;

    // carry-propagate add of the two reduced rows
    assign mag_prod = in_rows.sum_row + in_rows.carry_row;

    // sign restore over the whole 64-bit product
    assign prod = in_rows.negate ? -mag_prod : mag_prod;

    assign rsp_d.hi = prod[2*mul_pkg::WIDTH-1:mul_pkg::WIDTH];
    assign rsp_d.lo = prod[mul_pkg::WIDTH-1:0];

    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // held while the consumer stalls
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_rsp <= rsp_d;
        end
    end

endmodule

// ==== source/reduce_stage.sv ====
module reduce_stage (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  mul_pkg::cond_t in_cond,
    input  logic           out_ready,
    output logic           in_ready,
    output logic           out_valid,
    output mul_pkg::rows_t out_rows
);

    mul_pkg::columns_t columns;
    mul_pkg::product_t sum_row;
    mul_pkg::product_t carry_row;

    partial_product_gen pp_gen_i (
        .mag_a   (in_cond.mag_a),
        .mag_b   (in_cond.mag_b),
        .columns (columns)
    );

    dadda_tree tree_i (
        .columns   (columns),
        .sum_row   (sum_row),
        .carry_row (carry_row)
    );

    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    // sign travels with the rows to the final stage
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_rows.sum_row   <= sum_row;
            out_rows.carry_row <= carry_row;
            out_rows.negate    <= in_cond.negate;
        end
    end

endmodule

// ==== source/operand_stage.sv ====
module operand_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  mul_pkg::mul_req_t in_req,
    input  logic              out_ready,
    output logic              in_ready,
    output logic              out_valid,
    output mul_pkg::cond_t    out_cond
);

    logic           neg_a;
    logic           neg_b;
    mul_pkg::cond_t cond_d;

    // only signed mode treats the top bit as a sign
    assign neg_a = in_req.is_signed & in_req.a[mul_pkg::WIDTH-1];
    assign neg_b = in_req.is_signed & in_req.b[mul_pkg::WIDTH-1];

    // the most negative value maps onto itself, which is the right unsigned magnitude
    assign cond_d.mag_a  = neg_a ? -in_req.a : in_req.a;
    assign cond_d.mag_b  = neg_b ? -in_req.b : in_req.b;
    assign cond_d.negate = neg_a ^ neg_b;

    assign in_ready = ~out_valid | out_ready;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
        end
        else if (in_ready)
        begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
        begin
            out_cond <= cond_d;
        end
    end

endmodule

// ==== source/dadda_tree.sv ====
module dadda_tree (
    input  mul_pkg::columns_t columns,
    output mul_pkg::product_t sum_row,
    output mul_pkg::product_t carry_row
);

    localparam int W    = mul_pkg::WIDTH;
    // one extra column on top catches carries out of the last product column
    localparam int NCOL = 2 * mul_pkg::WIDTH;

    function automatic int step_count();
        int k;
        k = 0;
        while (mul_pkg::dadda_limit(k + 1) < W)
            k++;
        return k + 1;
    endfunction

    localparam int NSTEP = step_count();

    // replays the reduction up to step s and reports on column w
    // what 0 gives the height after step s, 1 the full adders and 2 the half adders of step s
    function automatic int tree_plan(int s, int w, int what);
        int h [NCOL];
        int cin;
        int heff;
        int lim;
        int nf;
        int nh;
        int res;
        res = 0;
        for (int c = 0; c < NCOL; c++)
            h[c] = (c < W) ? c + 1 : ((c < 2 * W - 1) ? 2 * W - 1 - c : 0);
        if (what == 0 && s == 0)
            res = h[w];
        for (int t = 1; t <= s; t++)
        begin
            lim = mul_pkg::dadda_limit(NSTEP - t);
            cin = 0;
            for (int c = 0; c < NCOL; c++)
            begin
                heff = h[c] + cin;
                nf = 0;
                nh = 0;
                if (c < NCOL - 1 && heff > lim)
                begin
                    nf = (heff - lim) / 2;
                    nh = (heff - lim) % 2;
                end
                h[c] = heff - 2 * nf - nh;
                cin = nf + nh;
                if (t == s && c == w)
                    res = (what == 0) ? h[c] : ((what == 1) ? nf : nh);
            end
        end
        return res;
    endfunction

    for (genvar s = 0; s <= NSTEP; s++)
    begin : g_lvl
        logic [W-1:0] col [NCOL];

        if (s == 0)
        begin : g_init
            for (genvar w = 0; w < NCOL; w++)
            begin : g_col
                if (w < mul_pkg::COLS)
                begin : g_pp
                    assign col[w] = columns[w];
                end
                else
                begin : g_top
                    assign col[w] = '0;
                end
            end
        end
        else
        begin : g_step
            // carries produced in this step, column w feeds column w + 1
            logic [W-1:0] cy [NCOL-1];

            for (genvar w = 0; w < NCOL; w++)
            begin : g_col
                localparam int NF   = tree_plan(s, w, 1);
                localparam int NH   = tree_plan(s, w, 2);
                localparam int NC   = (w == 0) ? 0 : tree_plan(s, w - 1, 1) + tree_plan(s, w - 1, 2);
                localparam int BASE = 3 * NF + 2 * NH;
                localparam int NK   = tree_plan(s - 1, w, 0) - BASE;
                localparam int USED = NF + NH + NC + NK;

                // sums first, then incoming carries, then bits left untouched
                for (genvar k = 0; k < NF; k++)
                begin : g_fa
                    assign {cy[w][k], col[w][k]} = g_lvl[s-1].col[w][3*k]
                                                 + g_lvl[s-1].col[w][3*k+1]
                                                 + g_lvl[s-1].col[w][3*k+2];
                end
                if (NH > 0)
                begin : g_ha
                    assign {cy[w][NF], col[w][NF]} = g_lvl[s-1].col[w][3*NF]
                                                   + g_lvl[s-1].col[w][3*NF+1];
                end
                for (genvar k = 0; k < NC; k++)
                begin : g_cin
                    assign col[w][NF+NH+k] = cy[w-1][k];
                end
                for (genvar k = 0; k < NK; k++)
                begin : g_keep
                    assign col[w][NF+NH+NC+k] = g_lvl[s-1].col[w][BASE+k];
                end
                for (genvar k = USED; k < W; k++)
                begin : g_pad
                    assign col[w][k] = 1'b0;
                end
                if (w < NCOL - 1)
                begin : g_cy_pad
                    for (genvar k = NF + NH; k < W; k++)
                    begin : g_bit
                        assign cy[w][k] = 1'b0;
                    end
                end
            end
        end
    end

    // every column now holds at most two bits
    for (genvar w = 0; w < NCOL; w++)
    begin : g_out
        assign sum_row[w]   = g_lvl[NSTEP].col[w][0];
        assign carry_row[w] = g_lvl[NSTEP].col[w][1];
    end

endmodule

// ==== source/partial_product_gen.sv ====
module partial_product_gen (
    input  mul_pkg::operand_t mag_a,
    input  mul_pkg::operand_t mag_b,
    output mul_pkg::columns_t columns
);

    // column w holds a[i] & b[j] for every i + j == w
    for (genvar w = 0; w < mul_pkg::COLS; w++)
    begin : g_col
        // lowest b index that lands in this column, and the number of products
        localparam int JLO = (w < mul_pkg::WIDTH) ? 0 : w - mul_pkg::WIDTH + 1;
        localparam int NB  = (w < mul_pkg::WIDTH) ? w + 1 : 2 * mul_pkg::WIDTH - 1 - w;

        for (genvar p = 0; p < mul_pkg::WIDTH; p++)
        begin : g_bit
            if (p < NB)
            begin : g_and
                assign columns[w][p] = mag_a[w - JLO - p] & mag_b[JLO + p];
            end
            else
            begin : g_zero
                assign columns[w][p] = 1'b0;
            end
        end
    end

endmodule

// ==== source/mul_pkg.sv ====
package mul_pkg;

    localparam int WIDTH = 32;
    // partial product columns, weights 0 .. 2*WIDTH-2
    localparam int COLS  = 2 * WIDTH - 1;

    typedef logic [WIDTH-1:0]           operand_t;
    typedef logic [2*WIDTH-1:0]         product_t;
    typedef logic [COLS-1:0][WIDTH-1:0] columns_t;

    typedef struct packed {
        operand_t a;
        operand_t b;
        logic     is_signed;
    } mul_req_t;

    typedef struct packed {
        operand_t hi;
        operand_t lo;
    } mul_rsp_t;

    typedef struct packed {
        operand_t mag_a;
        operand_t mag_b;
        logic     negate;
    } cond_t;

    typedef struct packed {
        product_t sum_row;
        product_t carry_row;
        logic     negate;
    } rows_t;

    // column height allowed after reduction step number step, 2 3 4 6 9 13 19 28 ...
    function automatic int dadda_limit(int step);
        int d;
        d = 2;
        for (int i = 0; i < step; i++)
            d = d * 3 / 2;
        return d;
    endfunction

endpackage
